// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  // cache geometry
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 16;
  localparam int WORDS_PER_LINE = 8;
  localparam int BEATS_PER_LINE = 4;

  // address split: tag [31:9], set [8:5], offset [4:0]
  localparam int ADDR_W   = 32;
  localparam int TAG_W    = 23;
  localparam int SET_W    = 4;
  localparam int OFFSET_W = 5;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [SET_W-1:0]  set_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [WORDS_PER_LINE*32-1:0] line_t;

  // cpu byte read mask
  typedef logic [3:0] bmask_t;
  // byte write mask over a whole line
  typedef logic [WORDS_PER_LINE*4-1:0] lmask_t;

  typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

  // tree pseudo-lru, one bit per inner node
  typedef logic [NUM_WAYS-2:0] plru_bits_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    FILL,
    REREAD
  } cache_state_e;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_HIT_READ,
    OP_FILL_WRITE
  } sram_op_e;

endpackage

// ==== hdl/instr_serve.sv ====
`timescale 1ns/1ps

module instr_serve (
  input  logic              clk,
  input  logic              arst_n,
  input  cache_pkg::addr_t  cpu_addr,
  input  cache_pkg::bmask_t cpu_rmask,
  input  logic              rdata_resp,
  output cache_pkg::addr_t  req_addr,
  output cache_pkg::bmask_t req_rmask,
  output logic              req_read
);

  logic take;

  // free slot, or the pending one retires this cycle
  assign take = !req_read || rdata_resp;

  assign req_read = (req_rmask != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_rmask <= '0;
    end else if (take) begin
      // a zero mask here simply clears the slot
      req_rmask <= cpu_rmask;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_addr <= cpu_addr;
    end
  end

  // only one request in flight
  a_no_overlap : assert property (
    @(posedge clk) disable iff (!arst_n)
    req_read && !rdata_resp |-> cpu_rmask == '0
  ) else $error("new cpu request while one is still pending");

endmodule

// ==== hdl/instr_cache_fsm.sv ====
`timescale 1ns/1ps

module instr_cache_fsm (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req_read,
  input  logic                  hit,
  input  logic                  mem_ready,
  input  logic                  mem_rvalid,
  input  cache_pkg::addr_t      mem_raddr,
  output cache_pkg::sram_op_e   sram_op,
  output logic                  array_en,
  output cache_pkg::beat_idx_t  beat_sel,
  output logic                  last_beat,
  output logic                  mem_read,
  output logic                  fill_busy,
  output logic                  rdata_resp
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e state_next;

  logic [cache_pkg::BEATS_PER_LINE-1:0] beats_rcvd;
  logic [cache_pkg::BEATS_PER_LINE-1:0] beat_bit;

  // beat position comes from the address carried with the data
  assign beat_sel = mem_raddr[4:3];

  always_comb begin
    beat_bit = '0;
    beat_bit[beat_sel] = 1'b1;
  end

  assign last_beat = (state == cache_pkg::FILL) && mem_rvalid &&
                     ((beats_rcvd | beat_bit) == '1);

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::IDLE: begin
        // hold off while the previous response is still out
        if (req_read && !rdata_resp) begin
          state_next = cache_pkg::LOOKUP;
        end
      end
      cache_pkg::LOOKUP: begin
        if (hit) begin
          state_next = cache_pkg::IDLE;
        end else begin
          state_next = cache_pkg::MISS_REQ;
        end
      end
      cache_pkg::MISS_REQ: begin
        if (mem_ready) begin
          state_next = cache_pkg::FILL;
        end
      end
      cache_pkg::FILL: begin
        if (last_beat) begin
          state_next = cache_pkg::REREAD;
        end
      end
      cache_pkg::REREAD: begin
        state_next = cache_pkg::LOOKUP;
      end
      default: begin
        state_next = cache_pkg::IDLE;
      end
    endcase
  end

  always_comb begin
    sram_op = cache_pkg::OP_NONE;
    if (state == cache_pkg::IDLE && req_read && !rdata_resp) begin
      sram_op = cache_pkg::OP_HIT_READ;
    end else if (state == cache_pkg::REREAD) begin
      sram_op = cache_pkg::OP_HIT_READ;
    end else if (state == cache_pkg::FILL && mem_rvalid) begin
      sram_op = cache_pkg::OP_FILL_WRITE;
    end
  end

  assign array_en  = (sram_op != cache_pkg::OP_NONE);
  assign mem_read  = (state == cache_pkg::MISS_REQ);
  assign fill_busy = (state == cache_pkg::FILL);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= cache_pkg::IDLE;
      beats_rcvd <= '0;
      rdata_resp <= 1'b0;
    end else begin
      state      <= state_next;
      rdata_resp <= (state == cache_pkg::LOOKUP) && hit;
      if (state != cache_pkg::FILL || last_beat) begin
        beats_rcvd <= '0;
      end else if (mem_rvalid) begin
        beats_rcvd <= beats_rcvd | beat_bit;
      end
    end
  end

  a_beat_in_fill : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_rvalid |-> fill_busy
  ) else $error("memory beat outside of a fill");

  a_beat_unique : assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_rvalid && fill_busy |-> !beats_rcvd[beat_sel]
  ) else $error("beat %0d delivered twice in one fill", beat_sel);

endmodule

// ==== hdl/plru.sv ====
`timescale 1ns/1ps

module plru (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            rdata_resp,
  input  cache_pkg::set_t set,
  input  cache_pkg::way_t visit_way,
  output cache_pkg::way_t victim_way
);

  // bit 0 picks the pair, bit 1 ways 0/1, bit 2 ways 2/3
  cache_pkg::plru_bits_t tree [cache_pkg::NUM_SETS];
  cache_pkg::plru_bits_t cur;

  assign cur = tree[set];

  always_comb begin
    if (!cur[0]) begin
      victim_way = {1'b0, cur[1]};
    end else begin
      victim_way = {1'b1, cur[2]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
        tree[s] <= '0;
      end
    end else if (rdata_resp) begin
      // point the root at the other pair
      tree[set][0] <= ~visit_way[1];
      if (visit_way[1]) begin
        tree[set][2] <= ~visit_way[0];
      end else begin
        tree[set][1] <= ~visit_way[0];
      end
    end
  end

endmodule

// ==== hdl/cache_way_array.sv ====
`timescale 1ns/1ps

module cache_way_array (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              en,
  input  logic              we,
  input  cache_pkg::lmask_t wmask,
  input  cache_pkg::set_t   set,
  input  cache_pkg::line_t  wdata,
  input  cache_pkg::tag_t   wtag,
  input  logic              wvalid,
  output cache_pkg::line_t  rdata,
  output cache_pkg::tag_t   rtag,
  output logic              rvalid
);

  cache_pkg::line_t data_mem [cache_pkg::NUM_SETS];
  cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_SETS];

  logic [cache_pkg::NUM_SETS-1:0] valid;

  // data sram, byte masked write, sync read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int b = 0; b < $bits(cache_pkg::lmask_t); b++) begin
          if (wmask[b]) begin
            data_mem[set][b*8 +: 8] <= wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata <= data_mem[set];
      end
    end
  end

  // tag sram, written once the line is complete
  always_ff @(posedge clk) begin
    if (en) begin
      if (we && wvalid) begin
        tag_mem[set] <= wtag;
      end else if (!we) begin
        rtag <= tag_mem[set];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid  <= '0;
      rvalid <= 1'b0;
    end else if (en) begin
      if (we && wvalid) begin
        valid[set] <= 1'b1;
      end else if (!we) begin
        rvalid <= valid[set];
      end
    end
  end

endmodule

// ==== hdl/instr_cache.sv ====
`timescale 1ns/1ps

module instr_cache (
  input  logic              clk,
  input  logic              arst_n,
  input  cache_pkg::addr_t  req_addr,
  input  cache_pkg::bmask_t req_rmask,
  input  logic              req_read,
  input  logic              mem_ready,
  input  cache_pkg::beat_t  mem_rdata,
  input  cache_pkg::addr_t  mem_raddr,
  input  logic              mem_rvalid,
  output cache_pkg::word_t  rdata,
  output logic              rdata_resp,
  output cache_pkg::addr_t  mem_addr,
  output logic              mem_read,
  output logic              fill_busy
);

  cache_pkg::tag_t      req_tag;
  cache_pkg::set_t      req_set;
  cache_pkg::sram_op_e  sram_op;
  cache_pkg::beat_idx_t beat_sel;
  cache_pkg::way_t      victim_way;
  cache_pkg::way_t      hit_way;
  cache_pkg::line_t     fill_data;
  cache_pkg::lmask_t    fill_mask;
  cache_pkg::line_t     hit_line;
  cache_pkg::word_t     hit_word;

  logic array_en;
  logic hit;
  logic last_beat;

  logic [cache_pkg::NUM_WAYS-1:0] hit_vec;
  logic [cache_pkg::NUM_WAYS-1:0] way_we;
  logic [cache_pkg::NUM_WAYS-1:0] way_rvalid;
  cache_pkg::line_t way_rdata [cache_pkg::NUM_WAYS];
  cache_pkg::tag_t  way_rtag  [cache_pkg::NUM_WAYS];

  assign req_tag = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_set = req_addr[cache_pkg::OFFSET_W +: cache_pkg::SET_W];

  instr_cache_fsm u_fsm (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_read   (req_read),
    .hit        (hit),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_raddr  (mem_raddr),
    .sram_op    (sram_op),
    .array_en   (array_en),
    .beat_sel   (beat_sel),
    .last_beat  (last_beat),
    .mem_read   (mem_read),
    .fill_busy  (fill_busy),
    .rdata_resp (rdata_resp)
  );

  plru u_plru (
    .clk        (clk),
    .arst_n     (arst_n),
    .rdata_resp (rdata_resp),
    .set        (req_set),
    .visit_way  (hit_way),
    .victim_way (victim_way)
  );

  // every way sees the beat, the mask picks the 8 bytes
  assign fill_data = {cache_pkg::BEATS_PER_LINE{mem_rdata}};

  always_comb begin
    fill_mask = '0;
    fill_mask[beat_sel*8 +: 8] = 8'hff;
  end

  for (genvar i = 0; i < cache_pkg::NUM_WAYS; i++) begin : g_way
    assign way_we[i] = (sram_op == cache_pkg::OP_FILL_WRITE) &&
                       (victim_way == cache_pkg::way_t'(i));
    assign hit_vec[i] = way_rvalid[i] && (way_rtag[i] == req_tag);

    cache_way_array u_array (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (array_en),
      .we     (way_we[i]),
      .wmask  (fill_mask),
      .set    (req_set),
      .wdata  (fill_data),
      .wtag   (req_tag),
      .wvalid (last_beat),
      .rdata  (way_rdata[i]),
      .rtag   (way_rtag[i]),
      .rvalid (way_rvalid[i])
    );
  end

  assign hit = |hit_vec;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  assign hit_line = way_rdata[hit_way];
  assign hit_word = hit_line[req_addr[4:2]*32 +: 32];

  // bytes outside the read mask come back as zero
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rdata[b*8 +: 8] = req_rmask[b] ? hit_word[b*8 +: 8] : 8'h00;
    end
  end

  assign mem_addr = mem_read ? {req_tag, req_set, {cache_pkg::OFFSET_W{1'b0}}} : '0;

  a_hit_onehot : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(hit_vec)
  ) else $error("tag hit in more than one way of set %0d", req_set);

endmodule

// ==== hdl/instr_cache_top.sv ====
`timescale 1ns/1ps

module instr_cache_top (
  input  logic              clk,
  input  logic              arst_n,
  input  cache_pkg::addr_t  cpu_addr,
  input  cache_pkg::bmask_t cpu_rmask,
  output cache_pkg::word_t  rdata,
  output logic              rdata_resp,
  output cache_pkg::addr_t  mem_addr,
  output logic              mem_read,
  input  logic              mem_ready,
  input  cache_pkg::beat_t  mem_rdata,
  input  cache_pkg::addr_t  mem_raddr,
  input  logic              mem_rvalid,
  output logic              fill_busy
);

  cache_pkg::addr_t  req_addr;
  cache_pkg::bmask_t req_rmask;
  logic              req_read;

  instr_serve u_serve (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpu_addr   (cpu_addr),
    .cpu_rmask  (cpu_rmask),
    .rdata_resp (rdata_resp),
    .req_addr   (req_addr),
    .req_rmask  (req_rmask),
    .req_read   (req_read)
  );

  instr_cache u_cache (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_addr   (req_addr),
    .req_rmask  (req_rmask),
    .req_read   (req_read),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .mem_raddr  (mem_raddr),
    .mem_rvalid (mem_rvalid),
    .rdata      (rdata),
    .rdata_resp (rdata_resp),
    .mem_addr   (mem_addr),
    .mem_read   (mem_read),
    .fill_busy  (fill_busy)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

// ==== verification/instr_cache_tb.sv ====
`timescale 1ns/1ps

module instr_cache_tb;

  localparam int RESP_TIMEOUT = 200;
  localparam int STALL_CYCLES = 8;
  localparam int RAND_READS   = 60;

  logic              clk;
  logic              arst_n;
  cache_pkg::addr_t  cpu_addr;
  cache_pkg::bmask_t cpu_rmask;
  cache_pkg::word_t  rdata;
  logic              rdata_resp;
  cache_pkg::addr_t  mem_addr;
  logic              mem_read;
  logic              mem_ready;
  cache_pkg::beat_t  mem_rdata;
  cache_pkg::addr_t  mem_raddr;
  logic              mem_rvalid;
  logic              fill_busy;

  logic [31:0]      rng_state = 32'd82;
  cache_pkg::word_t exp_word;
  int               ready_stall;

  // five tags into set 7 where tag 4 evicts tag 0 before it comes back
  int repl_seq [10] = '{0, 1, 2, 3, 4, 1, 2, 3, 0, 4};

  // reference cache with tags, valid bits and tree plru per set
  cache_pkg::tag_t       ref_tag   [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  logic                  ref_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
  cache_pkg::plru_bits_t ref_tree  [cache_pkg::NUM_SETS];

  tb_clock_gen u_clk_gen (
    .clk (clk)
  );

  instr_cache_top u_instr_cache_top (.*);

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // memory word as a mix of its whole address
  function automatic cache_pkg::word_t word_at(input cache_pkg::addr_t a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return w ^ {w[15:0], w[31:16]} ^ 32'h5ac3_0f96;
  endfunction

  function automatic cache_pkg::word_t expected_rdata(input cache_pkg::addr_t a,
                                                      input cache_pkg::bmask_t m);
    cache_pkg::word_t w;
    w = word_at(a);
    for (int b = 0; b < 4; b++) begin
      if (!m[b]) begin
        w[b*8 +: 8] = 8'h00;
      end
    end
    return w;
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at time %0t: gave up waiting for %s", $time, what);
    abort_run();
  endtask

  // predicts hit or miss and updates the model like the cache would
  task automatic ref_access(input cache_pkg::addr_t addr, output logic miss);
    cache_pkg::tag_t t;
    cache_pkg::set_t s;
    int way;
    t = addr[31:9];
    s = addr[8:5];
    way = -1;
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      if (ref_valid[s][w] && ref_tag[s][w] == t) begin
        way = w;
      end
    end
    miss = (way < 0);
    if (miss) begin
      // root bit picks the pair, then the pair bit picks the way
      if (!ref_tree[s][0]) begin
        way = ref_tree[s][1] ? 1 : 0;
      end else begin
        way = ref_tree[s][2] ? 3 : 2;
      end
      ref_tag[s][way]   = t;
      ref_valid[s][way] = 1'b1;
    end
    // bits point away from the way just used
    ref_tree[s][0] = (way < 2);
    if (way < 2) begin
      ref_tree[s][1] = (way == 0);
    end else begin
      ref_tree[s][2] = (way == 2);
    end
  endtask

  // memory side of one line read
  task automatic serve_fill(input cache_pkg::addr_t line);
    int delay;
    int order [4];
    int j;
    int tmp;
    cache_pkg::addr_t a;
    check_eq(mem_addr, line, "mem_addr of the line read");
    delay = (ready_stall > 0) ? ready_stall : int'(xorshift32() % 4);
    for (int i = 0; i < delay; i++) begin
      @(posedge clk);
      #10;
      check_eq(mem_read, 1'b1, "mem_read held while mem_ready is low");
      check_eq(mem_addr, line, "mem_addr stable while stalled");
      check_eq(rdata_resp, 1'b0, "rdata_resp during the stall");
    end
    mem_ready = 1'b1;
    @(posedge clk);
    #10;
    mem_ready = 1'b0;
    check_eq(fill_busy, 1'b1, "fill_busy after the read is accepted");
    check_eq(mem_read, 1'b0, "mem_read after the read is accepted");
    for (int i = 0; i < 4; i++) begin
      order[i] = i;
    end
    for (int i = 3; i > 0; i--) begin
      j = int'(xorshift32() % (i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 4; k++) begin
      // random gap before each beat
      repeat (xorshift32() % 3) begin
        @(posedge clk);
        #10;
      end
      check_eq(fill_busy, 1'b1, "fill_busy while beats are due");
      check_eq(rdata_resp, 1'b0, "rdata_resp during the fill");
      a = line | cache_pkg::addr_t'(order[k] * 8);
      mem_raddr  = a;
      mem_rdata  = {word_at(a + 4), word_at(a)};
      mem_rvalid = 1'b1;
      @(posedge clk);
      #10;
      mem_rvalid = 1'b0;
    end
    check_eq(fill_busy, 1'b0, "fill_busy after the last beat");
  endtask

  task automatic read_word(input cache_pkg::addr_t addr, input cache_pkg::bmask_t mask);
    logic pred_miss;
    logic saw_miss;
    logic got;
    int   cyc;
    ref_access(addr, pred_miss);
    exp_word  = expected_rdata(addr, mask);
    cpu_addr  = addr;
    cpu_rmask = mask;
    saw_miss  = 1'b0;
    got       = 1'b0;
    cyc       = 0;
    while (!got && cyc < RESP_TIMEOUT) begin
      @(posedge clk);
      #10;
      cpu_rmask = '0;
      cyc++;
      if (mem_read) begin
        saw_miss = 1'b1;
        serve_fill({addr[31:5], 5'b0});
      end
      got = rdata_resp;
    end
    if (!got) begin
      report_timeout($sformatf("rdata_resp of the read at %h", addr));
    end
    check_eq(saw_miss, pred_miss, $sformatf("mem_read for the read at %h", addr));
    if (!pred_miss) begin
      // accepted at the first edge, answered two edges later
      check_eq(cyc - 1, 2, "hit latency in cycles");
    end
    @(posedge clk);
    #10;
    check_eq(rdata_resp, 1'b0, "rdata_resp is a one cycle pulse");
  endtask

  // compares every response with the reference word
  always begin
    @(posedge clk);
    #10;
    if (rdata_resp) begin
      check_eq(rdata, exp_word, $sformatf("rdata for address %h", cpu_addr));
    end
    if (!mem_read) begin
      check_eq(mem_addr, 32'h0, "mem_addr while mem_read is low");
    end
  end

  initial begin
    cache_pkg::addr_t  a;
    cache_pkg::bmask_t m;
    logic [31:0]       r;
    arst_n      = 1'b0;
    cpu_addr    = '0;
    cpu_rmask   = '0;
    mem_ready   = 1'b0;
    mem_rdata   = '0;
    mem_raddr   = '0;
    mem_rvalid  = 1'b0;
    exp_word    = '0;
    ready_stall = 0;
    for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
      ref_tree[s] = '0;
      for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
      end
    end
    repeat (4) @(posedge clk);
    #10;
    arst_n = 1'b1;

    check_eq(rdata_resp, 1'b0, "rdata_resp after reset");
    check_eq(mem_read, 1'b0, "mem_read after reset");
    check_eq(fill_busy, 1'b0, "fill_busy after reset");

    // cold miss, then all eight words of that line hit
    read_word(32'h0000_1234, 4'hf);
    for (int i = 0; i < 8; i++) begin
      read_word(32'h0000_1220 + i * 4, 4'hf);
    end

    for (int i = 0; i < 10; i++) begin
      a = {cache_pkg::tag_t'(23'h100 + repl_seq[i]), 4'd7, 3'(i), 2'b00};
      read_word(a, 4'hf);
    end

    // six tags over sets 2 and 3 with random masks
    for (int n = 0; n < RAND_READS; n++) begin
      r = xorshift32();
      a = {cache_pkg::tag_t'(23'h200 + r[2:0] % 6), 3'b001, r[3], r[6:4], 2'b00};
      m = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
      read_word(a, m);
    end

    ready_stall = STALL_CYCLES;
    read_word(32'h0008_0ae0, 4'hf);
    ready_stall = 0;

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/cache_pkg.sv
hdl/instr_serve.sv
hdl/instr_cache_fsm.sv
hdl/plru.sv
hdl/cache_way_array.sv
hdl/instr_cache.sv
hdl/instr_cache_top.sv
verification/tb_clock_gen.sv
verification/instr_cache_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := instr_cache_tb
FILELIST  := vlog.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@grep -q "Result: PASSED" $(SIM_LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
